// File: common/srcPkg.sv
package srcPkg;

    localparam int wordBits    = 32;                // data and address width.
    localparam int regCount    = 16;                // general registers.
    localparam int regSelBits  = $clog2(regCount);  // register field width.
    localparam int memWords    = 512;               // ram depth.
    localparam int memAddrBits = $clog2(memWords);  // low mar bits used.
    localparam int opBits      = 5;                 // opcode field.
    localparam int constBits   = 19;                // immediate field.
    localparam int aluOpBits   = 2;

    localparam logic [aluOpBits-1:0] aluAdd = 2'd0; // also the idle code.
    localparam logic [aluOpBits-1:0] aluSub = 2'd1;
    localparam logic [aluOpBits-1:0] aluAnd = 2'd2;
    localparam logic [aluOpBits-1:0] aluOr  = 2'd3;

    localparam logic [1:0] condZero    = 2'b00; // brzr.
    localparam logic [1:0] condNonZero = 2'b01; // brnz.
    localparam logic [1:0] condPlus    = 2'b10; // brpl, sign clear.
    localparam logic [1:0] condMinus   = 2'b11; // brmi, sign set.

    typedef enum logic [opBits-1:0] {
        opLd   = 5'b00000,
        opSt   = 5'b00010,
        opAdd  = 5'b00011,
        opSub  = 5'b00100,
        opAnd  = 5'b01010,
        opOr   = 5'b01011,
        opAddi = 5'b01100,
        opAndi = 5'b01101,
        opOri  = 5'b01110,
        opBr   = 5'b10011,  // condition in c2.
        opIn   = 5'b10110,
        opOut  = 5'b10111,
        opNop  = 5'b11010,
        opHalt = 5'b11011
    } opcode_e;

    typedef enum logic [3:0] {
        stDefault = 4'b0000,
        stT0      = 4'b0001,
        stT1      = 4'b0010,
        stT2      = 4'b0011,
        stT3      = 4'b0100,
        stT4      = 4'b0101,
        stT5      = 4'b0110,
        stT6      = 4'b0111,
        stT7      = 4'b1000,
        stHalt    = 4'b1110,
        stMemWait = 4'b1111
    } stepState_e;

    typedef union packed {
        struct packed {
            opcode_e                                 op;
            logic [regSelBits-1:0]                   ra;
            logic [regSelBits-1:0]                   rb;
            logic [regSelBits-1:0]                   rc;
            logic [wordBits-opBits-3*regSelBits-1:0] spare;  // unused low bits.
        } rFormat;
        struct packed {
            opcode_e               op;
            logic [regSelBits-1:0] ra;
            logic [regSelBits-1:0] rb;  // low two bits are c2 on branches.
            logic [constBits-1:0]  c;
        } iFormat;
    } instrWord_u;

endpackage

// File: common/ctrlIf.sv
interface ctrlIf;
    import srcPkg::*;

    logic gra, grb, grc;                   // register field select.
    logic rIn, rOut, baOut, cOut;          // register bank and constant.
    logic pcOut, pcIn, incPc, irIn;        // pc and ir.
    logic yIn, zIn, zLowOut;               // alu registers.
    logic [aluOpBits-1:0] aluOp;
    logic marIn, mdrIn, mdrOut;            // memory registers.
    logic memRead, memWrite;
    logic inPortOut, outPortIn;            // io ports.
    logic conIn;                           // branch test.
    logic conFlag;                         // back from the alu.
    instrWord_u instr;                     // ir contents.

    modport seq (
        output gra, grb, grc, rIn, rOut, baOut, cOut,
        output pcOut, pcIn, incPc, irIn,
        output yIn, zIn, zLowOut, aluOp,
        output marIn, mdrIn, mdrOut, memRead, memWrite,
        output inPortOut, outPortIn, conIn,
        input  conFlag, instr
    );

    modport dp (
        input  gra, grb, grc, rIn, rOut, baOut, cOut,
        input  pcOut, pcIn, incPc, irIn,
        input  yIn, zIn, zLowOut, aluOp,
        input  marIn, mdrIn, mdrOut, memRead, memWrite,
        input  inPortOut, outPortIn, conIn,
        input  instr,
        output conFlag
    );

endinterface

// File: hw/controlSequencer/controlSequencer.sv
module controlSequencer (
    input  logic clock,
    input  logic rstN,
    ctrlIf.seq   ctrl,
    output logic halted
);
    import srcPkg::*;

    stepState_e state;
    stepState_e nextState;
    stepState_e resumeState;                // where memWait goes next.
    opcode_e    op;
    logic isAluReg, isAluImm, isAlu, isAddi;
    logic isLd, isSt, isBr, isIn, isOut;
    logic isHalt, isExec;
    logic t0, t1, t2, t3, t4, t5, t6, t7;   // step decode.
    logic [aluOpBits-1:0] aluSel;
    logic anyStrobe;

    assign op       = ctrl.instr.rFormat.op;
    assign isAluReg = op inside {opAdd, opSub, opAnd, opOr};
    assign isAluImm = op inside {opAddi, opAndi, opOri};
    assign isAlu    = isAluReg || isAluImm;
    assign isAddi   = (op == opAddi);       // only immediate with a base.
    assign isLd     = (op == opLd);
    assign isSt     = (op == opSt);
    assign isBr     = (op == opBr);
    assign isIn     = (op == opIn);
    assign isOut    = (op == opOut);
    assign isHalt   = (op == opHalt);
    assign isExec   = isAlu || isLd || isSt || isBr || isIn || isOut;

    always_comb begin
        case (op)
            opSub:         aluSel = aluSub;
            opAnd, opAndi: aluSel = aluAnd;
            opOr, opOri:   aluSel = aluOr;
            default:       aluSel = aluAdd;  // add, addi, address and target sums.
        endcase
    end

    always_comb begin
        nextState = state;
        case (state)
            stDefault: nextState = stT0;
            stT0:      nextState = stT1;
            stT1:      nextState = stMemWait;
            stMemWait: nextState = resumeState;
            stT2:      nextState = stT3;
            stT3: begin
                if (isHalt)
                    nextState = stHalt;
                else if (isExec)
                    nextState = stT4;
                else
                    nextState = stT0;          // nop and unused codes.
            end
            stT4:      nextState = (isIn || isOut) ? stT0 : stT5;
            stT5: begin
                if (isAlu)
                    nextState = stT0;
                else if (isLd)
                    nextState = stMemWait;     // data read for ld.
                else
                    nextState = stT6;
            end
            stT6:      nextState = stT0;
            stT7:      nextState = stT0;
            stHalt:    nextState = stHalt;     // held until reset.
            default:   nextState = stDefault;
        endcase
    end

    always_ff @(posedge clock) begin
        if (!rstN) begin
            state       <= stDefault;
            resumeState <= stT2;
        end else begin
            state <= nextState;
            if (nextState == stMemWait)
                resumeState <= (state == stT5) ? stT7 : stT2;  // ld ends in T7.
        end
    end

    assign t0 = (state == stT0);
    assign t1 = (state == stT1);
    assign t2 = (state == stT2);
    assign t3 = (state == stT3);
    assign t4 = (state == stT4);
    assign t5 = (state == stT5);
    assign t6 = (state == stT6);
    assign t7 = (state == stT7);

    // one term per step that uses the strobe.
    assign ctrl.gra       = (t3 && (isSt || isIn || isOut || isBr)) || (t5 && isAlu) || (t7 && isLd);
    assign ctrl.grb       = (t3 && (isAlu || isLd)) || (t4 && isSt);
    assign ctrl.grc       = t4 && isAluReg;
    assign ctrl.rIn       = (t3 && isIn) || (t5 && isAlu) || (t7 && isLd);
    assign ctrl.rOut      = (t3 && (isAlu || isLd || isSt || isOut || isBr))
                          || (t4 && (isAluReg || isSt));
    assign ctrl.baOut     = (t3 && (isLd || isAddi)) || (t4 && isSt);  // r0 means no base.
    assign ctrl.cOut      = (t4 && (isAluImm || isLd)) || (t5 && (isSt || isBr));
    assign ctrl.pcOut     = t0 || (t4 && isBr);
    assign ctrl.pcIn      = t1 || (t6 && isBr && ctrl.conFlag);        // taken branch only.
    assign ctrl.incPc     = t0;
    assign ctrl.irIn      = t2;
    assign ctrl.yIn       = (t3 && (isAlu || isLd)) || (t4 && (isSt || isBr));
    assign ctrl.zIn       = t0 || (t4 && (isAlu || isLd)) || (t5 && (isSt || isBr));
    assign ctrl.zLowOut   = t1 || (t5 && (isAlu || isLd)) || (t6 && (isSt || isBr));
    assign ctrl.aluOp     = ctrl.zIn ? aluSel : aluAdd;
    assign ctrl.marIn     = t0 || (t5 && isLd) || (t6 && isSt);
    assign ctrl.mdrIn     = t1 || (t3 && isSt) || (t5 && isLd);
    assign ctrl.mdrOut    = t2 || (t7 && isLd);
    assign ctrl.memRead   = t1 || (t5 && isLd);
    assign ctrl.memWrite  = t6 && isSt;
    assign ctrl.inPortOut = t3 && isIn;
    assign ctrl.outPortIn = t3 && isOut;
    assign ctrl.conIn     = t3 && isBr;

    assign anyStrobe = ctrl.gra || ctrl.grb || ctrl.grc || ctrl.rIn || ctrl.rOut
                     || ctrl.baOut || ctrl.cOut || ctrl.pcOut || ctrl.pcIn || ctrl.incPc
                     || ctrl.irIn || ctrl.yIn || ctrl.zIn || ctrl.zLowOut || ctrl.marIn
                     || ctrl.mdrIn || ctrl.mdrOut || ctrl.memRead || ctrl.memWrite
                     || ctrl.inPortOut || ctrl.outPortIn || ctrl.conIn || (ctrl.aluOp != aluAdd);

    assign halted = (state == stHalt);

    // ram data lands during the wait step.
    assert property (@(posedge clock) disable iff (!rstN)
        ctrl.memRead |=> state == stMemWait);

    // halt is final and quiet.
    assert property (@(posedge clock) disable iff (!rstN)
        state == stHalt |=> state == stHalt && !anyStrobe);

endmodule

// File: hw/datapath/regBank.sv
module regBank (
    input  logic                          clock,
    input  logic                          rstN,
    ctrlIf.dp                             ctrl,
    input  logic [srcPkg::wordBits-1:0]   busIn,
    output logic [srcPkg::wordBits-1:0]   regData
);
    import srcPkg::*;

    logic [wordBits-1:0]   regs [regCount];
    logic [regSelBits-1:0] regSel;

    // select and encode from the ir fields.
    always_comb begin
        regSel = '0;
        if (ctrl.gra)
            regSel = ctrl.instr.rFormat.ra;
        else if (ctrl.grb)
            regSel = ctrl.instr.rFormat.rb;
        else if (ctrl.grc)
            regSel = ctrl.instr.rFormat.rc;
    end

    always_ff @(posedge clock) begin
        if (!rstN) begin
            for (int i = 0; i < regCount; i++) begin
                regs[i] <= '0;
            end
        end else if (ctrl.rIn) begin
            regs[regSel] <= busIn;  // written at the end of the rIn step.
        end
    end

    // r0 as base reads zero.
    assign regData = (ctrl.baOut && regSel == '0) ? '0 : regs[regSel];

endmodule

// File: hw/datapath/aluUnit.sv
module aluUnit (
    input  logic                          clock,
    input  logic                          rstN,
    ctrlIf.dp                             ctrl,
    input  logic [srcPkg::wordBits-1:0]   busIn,
    output logic [srcPkg::wordBits-1:0]   zLow
);
    import srcPkg::*;

    logic [wordBits-1:0] y;
    logic [wordBits-1:0] z;
    logic [wordBits-1:0] aluResult;
    logic [1:0]          c2;
    logic                condMet;
    logic                conFf;

    assign c2 = ctrl.instr.iFormat.rb[1:0];  // branch condition field.

    always_ff @(posedge clock) begin
        if (ctrl.yIn)
            y <= busIn;
    end

    always_comb begin
        if (ctrl.incPc) begin
            aluResult = busIn + 1'b1;  // next pc.
        end else begin
            case (ctrl.aluOp)
                aluAdd:  aluResult = y + busIn;
                aluSub:  aluResult = y - busIn;
                aluAnd:  aluResult = y & busIn;
                aluOr:   aluResult = y | busIn;
                default: aluResult = y + busIn;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (ctrl.zIn)
            z <= aluResult;
    end

    assign zLow = z;

    always_comb begin
        case (c2)
            condZero:    condMet = (busIn == '0);
            condNonZero: condMet = (busIn != '0);
            condPlus:    condMet = !busIn[wordBits-1];
            condMinus:   condMet = busIn[wordBits-1];
            default:     condMet = 1'b0;
        endcase
    end

    always_ff @(posedge clock) begin
        if (!rstN)
            conFf <= 1'b0;
        else if (ctrl.conIn)
            conFf <= condMet;  // held until the next branch test.
    end

    assign ctrl.conFlag = conFf;

endmodule

// File: hw/datapath/memInterface.sv
module memInterface (
    input  logic                            clock,
    input  logic                            rstN,
    ctrlIf.dp                               ctrl,
    input  logic [srcPkg::wordBits-1:0]     busIn,
    input  logic                            loadEn,
    input  logic [srcPkg::memAddrBits-1:0]  loadAddr,
    input  logic [srcPkg::wordBits-1:0]     loadData,
    output logic [srcPkg::wordBits-1:0]     mdrData
);
    import srcPkg::*;

    logic [wordBits-1:0]    ram [memWords];
    logic [wordBits-1:0]    mar;
    logic [wordBits-1:0]    marNext;
    logic [memAddrBits-1:0] ramAddr;
    logic [wordBits-1:0]    ramQ;        // registered read data.
    logic [wordBits-1:0]    mdr;
    logic                   readPending;
    logic                   wrEn;
    logic [memAddrBits-1:0] wrAddr;
    logic [wordBits-1:0]    wrData;

    // address follows the bus on the marIn step.
    assign marNext = ctrl.marIn ? busIn : mar;
    assign ramAddr = marNext[memAddrBits-1:0];

    always_ff @(posedge clock) begin
        if (ctrl.marIn)
            mar <= busIn;
    end

    // preload in reset, memWrite otherwise.
    assign wrEn   = rstN ? ctrl.memWrite : loadEn;
    assign wrAddr = rstN ? ramAddr : loadAddr;
    assign wrData = rstN ? mdr : loadData;

    always_ff @(posedge clock) begin
        if (wrEn)
            ram[wrAddr] <= wrData;
    end

    always_ff @(posedge clock) begin
        if (ctrl.memRead)
            ramQ <= ram[ramAddr];
    end

    always_ff @(posedge clock) begin
        if (!rstN)
            readPending <= 1'b0;
        else
            readPending <= ctrl.memRead && ctrl.mdrIn;  // high in memWait.
    end

    always_ff @(posedge clock) begin
        if (readPending)
            mdr <= ramQ;
        else if (ctrl.mdrIn && !ctrl.memRead)
            mdr <= busIn;  // store data from a register.
    end

    assign mdrData = mdr;

    assert property (@(posedge clock) rstN |-> !loadEn);

    assert property (@(posedge clock) disable iff (!rstN)
        !(ctrl.memRead && ctrl.memWrite));

endmodule

// File: hw/miniSrc.sv
module miniSrc (
    input  logic                            clock,
    input  logic                            rstN,
    input  logic                            loadEn,
    input  logic [srcPkg::memAddrBits-1:0]  loadAddr,
    input  logic [srcPkg::wordBits-1:0]     loadData,
    input  logic [srcPkg::wordBits-1:0]     inPortData,
    output logic [srcPkg::wordBits-1:0]     outPortData,
    output logic                            outStrobe,
    output logic                            halted
);
    import srcPkg::*;

    ctrlIf ctrlBus ();

    logic [wordBits-1:0] busData;
    logic [wordBits-1:0] regData;
    logic [wordBits-1:0] zLow;
    logic [wordBits-1:0] mdrData;
    logic [wordBits-1:0] constData;   // sign-extended c field.
    logic [wordBits-1:0] pc;
    logic [wordBits-1:0] inPortReg;
    instrWord_u          ir;

    controlSequencer uSeq (
        .clock  (clock),
        .rstN   (rstN),
        .ctrl   (ctrlBus.seq),
        .halted (halted)
    );

    regBank uRegBank (
        .clock   (clock),
        .rstN    (rstN),
        .ctrl    (ctrlBus.dp),
        .busIn   (busData),
        .regData (regData)
    );

    aluUnit uAlu (
        .clock (clock),
        .rstN  (rstN),
        .ctrl  (ctrlBus.dp),
        .busIn (busData),
        .zLow  (zLow)
    );

    memInterface uMem (
        .clock    (clock),
        .rstN     (rstN),
        .ctrl     (ctrlBus.dp),
        .busIn    (busData),
        .loadEn   (loadEn),
        .loadAddr (loadAddr),
        .loadData (loadData),
        .mdrData  (mdrData)
    );

    assign constData     = {{(wordBits-constBits){ir.iFormat.c[constBits-1]}}, ir.iFormat.c};
    assign ctrlBus.instr = ir;

    // single driver per step.
    always_comb begin
        if (ctrlBus.rOut)
            busData = regData;
        else if (ctrlBus.pcOut)
            busData = pc;
        else if (ctrlBus.zLowOut)
            busData = zLow;
        else if (ctrlBus.mdrOut)
            busData = mdrData;
        else if (ctrlBus.inPortOut)
            busData = inPortReg;
        else if (ctrlBus.cOut)
            busData = constData;
        else
            busData = '0;
    end

    always_ff @(posedge clock) begin
        if (!rstN)
            pc <= '0;
        else if (ctrlBus.pcIn)
            pc <= busData;  // pc+1 in fetch, target on a taken branch.
    end

    always_ff @(posedge clock) begin
        if (!rstN)
            ir <= '0;
        else if (ctrlBus.irIn)
            ir <= busData;
    end

    always_ff @(posedge clock) begin
        inPortReg <= inPortData;  // sampled every cycle.
    end

    always_ff @(posedge clock) begin
        if (!rstN) begin
            outPortData <= '0;
            outStrobe   <= 1'b0;
        end else begin
            outStrobe <= ctrlBus.outPortIn;  // pulse follows the write.
            if (ctrlBus.outPortIn)
                outPortData <= busData;
        end
    end

    assert property (@(posedge clock) disable iff (!rstN)
        $onehot0({ctrlBus.rOut, ctrlBus.pcOut, ctrlBus.zLowOut,
                  ctrlBus.mdrOut, ctrlBus.inPortOut, ctrlBus.cOut}));

endmodule

// File: sim/clockGen.sv
module clockGen (
    output logic clock,
    output logic rstN,
    input  logic holdReset
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int resetCycles = 4;

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;      // 8 ns period.
    end

    initial begin
        rstN = 1'b0;
        repeat (resetCycles) @(posedge clock);
        while (holdReset)
            @(posedge clock);           // preload still running.
        @(negedge clock);
        rstN = 1'b1;                    // released on a falling edge.
    end

endmodule

// File: sim/miniSrcTb.sv
module miniSrcTb;
    timeunit 1ns;
    timeprecision 100ps;
    import srcPkg::*;

    localparam int resetCycles     = 4;
    localparam int cyclesPerInstr  = 40;
    localparam int slackCycles     = 200;
    localparam int haltQuietCycles = 50;

    logic                   clock;
    logic                   rstN;
    logic                   holdReset;
    logic                   loadEn;
    logic [memAddrBits-1:0] loadAddr;
    logic [wordBits-1:0]    loadData;
    logic [wordBits-1:0]    inPortData;
    logic [wordBits-1:0]    outPortData;
    logic                   outStrobe;
    logic                   halted;

    logic [wordBits-1:0] prog [$];      // program image.
    logic [wordBits-1:0] expQ [$];      // expected out words in order.
    logic [wordBits-1:0] expHead;
    int                  expCount;
    int                  strobeCount;
    int                  limitCycles;
    logic [wordBits-1:0] wordA;
    logic [wordBits-1:0] wordB;
    logic [wordBits-1:0] markNWord;     // printed when a branch falls through.
    logic [wordBits-1:0] markTWord;     // printed after every branch.

    clockGen uClockGen (
        .clock     (clock),
        .rstN      (rstN),
        .holdReset (holdReset)
    );

    miniSrc u_miniSrc (
        .clock       (clock),
        .rstN        (rstN),
        .loadEn      (loadEn),
        .loadAddr    (loadAddr),
        .loadData    (loadData),
        .inPortData  (inPortData),
        .outPortData (outPortData),
        .outStrobe   (outStrobe),
        .halted      (halted)
    );

    function automatic logic [wordBits-1:0] encodeR(opcode_e op, logic [3:0] ra, rb, rc);
        return {op, ra, rb, rc, 15'd0};
    endfunction

    function automatic logic [wordBits-1:0] encodeI(opcode_e op, logic [3:0] ra, rb,
                                                    logic [18:0] c);
        return {op, ra, rb, c};
    endfunction

    function automatic logic [wordBits-1:0] signExtend(logic [18:0] c);
        return {{13{c[18]}}, c};
    endfunction

    function automatic logic isTaken(logic [1:0] cond, logic [wordBits-1:0] value);
        case (cond)
            condZero:    return value == '0;
            condNonZero: return value != '0;
            condPlus:    return !value[31];     // zero counts as plus.
            default:     return value[31];
        endcase
    endfunction

    task automatic putWord(logic [wordBits-1:0] w);
        prog.push_back(w);
    endtask

    task automatic expectOut(logic [wordBits-1:0] w);
        expQ.push_back(w);
    endtask

    // a taken branch to +1 skips the first out.
    task automatic addBranchTest(logic [3:0] ra, logic [wordBits-1:0] value, logic [1:0] cond);
        putWord(encodeI(opBr, ra, {2'b00, cond}, 19'd1));
        putWord(encodeR(opOut, 4'd10, 4'd0, 4'd0));
        putWord(encodeR(opOut, 4'd11, 4'd0, 4'd0));
        if (!isTaken(cond, value))
            expectOut(markNWord);
        expectOut(markTWord);
    endtask

    task automatic buildProgram();
        logic [31:0] rnd;
        logic [18:0] cAdd;
        logic [18:0] cAnd;
        logic [18:0] cOr;
        logic [18:0] negC;
        logic [18:0] markN;
        logic [18:0] addr2;
        logic [18:0] off1;
        logic [wordBits-1:0] negWord;
        wordA = $urandom;
        wordB = $urandom;
        rnd = $urandom;
        cAdd = rnd[18:0];
        rnd = $urandom;
        cAnd = rnd[18:0];
        rnd = $urandom;
        cOr = rnd[18:0];
        rnd = $urandom;
        negC = rnd[18:0] | 19'h40000;           // sign bit set.
        rnd = $urandom;
        markN = rnd[18:0];
        off1 = {13'd0, rnd[24:19]};             // 0 to 63 past the base.
        addr2 = 19'h180 + {13'd0, rnd[30:25]};  // separate block for the r0 base.
        negWord = signExtend(negC);
        markNWord = signExtend(markN);
        markTWord = signExtend(markN ^ 19'd1);
        putWord(encodeR(opIn, 4'd1, 4'd0, 4'd0));
        putWord(encodeR(opOut, 4'd1, 4'd0, 4'd0));
        expectOut(wordA);
        putWord(encodeR(opIn, 4'd2, 4'd0, 4'd0));
        putWord(encodeR(opOut, 4'd2, 4'd0, 4'd0));
        expectOut(wordB);
        putWord(encodeR(opAdd, 4'd3, 4'd1, 4'd2));
        putWord(encodeR(opOut, 4'd3, 4'd0, 4'd0));
        expectOut(wordA + wordB);
        putWord(encodeR(opSub, 4'd3, 4'd1, 4'd2));
        putWord(encodeR(opOut, 4'd3, 4'd0, 4'd0));
        expectOut(wordA - wordB);
        putWord(encodeR(opAnd, 4'd3, 4'd1, 4'd2));
        putWord(encodeR(opOut, 4'd3, 4'd0, 4'd0));
        expectOut(wordA & wordB);
        putWord(encodeR(opOr, 4'd3, 4'd1, 4'd2));
        putWord(encodeR(opOut, 4'd3, 4'd0, 4'd0));
        expectOut(wordA | wordB);
        putWord(encodeI(opAddi, 4'd4, 4'd1, cAdd));
        putWord(encodeR(opOut, 4'd4, 4'd0, 4'd0));
        expectOut(wordA + signExtend(cAdd));
        putWord(encodeI(opAndi, 4'd4, 4'd1, cAnd));
        putWord(encodeR(opOut, 4'd4, 4'd0, 4'd0));
        expectOut(wordA & signExtend(cAnd));
        putWord(encodeI(opOri, 4'd4, 4'd1, cOr));
        putWord(encodeR(opOut, 4'd4, 4'd0, 4'd0));
        expectOut(wordA | signExtend(cOr));
        putWord(encodeR(opOr, 4'd0, 4'd1, 4'd2));   // leaves r0 nonzero for the base tests.
        putWord(encodeI(opAddi, 4'd5, 4'd0, 19'h100));
        putWord(encodeR(opOut, 4'd5, 4'd0, 4'd0));
        expectOut(32'h100);
        putWord(encodeI(opSt, 4'd2, 4'd5, off1));
        putWord(encodeI(opLd, 4'd6, 4'd0, 19'h100 + off1));  // same word by absolute address.
        putWord(encodeR(opOut, 4'd6, 4'd0, 4'd0));
        expectOut(wordB);
        putWord(encodeI(opSt, 4'd1, 4'd0, addr2));
        putWord(encodeI(opLd, 4'd7, 4'd5, addr2 - 19'h100)); // same word through r5.
        putWord(encodeR(opOut, 4'd7, 4'd0, 4'd0));
        expectOut(wordA);
        putWord(encodeR(opSub, 4'd12, 4'd1, 4'd1));  // r12 is zero.
        putWord(encodeI(opAddi, 4'd9, 4'd0, negC));
        putWord(encodeI(opAddi, 4'd10, 4'd0, markN));
        putWord(encodeI(opAddi, 4'd11, 4'd0, markN ^ 19'd1));
        addBranchTest(4'd12, 32'd0, condZero);
        addBranchTest(4'd5, 32'h100, condZero);
        addBranchTest(4'd5, 32'h100, condNonZero);
        addBranchTest(4'd12, 32'd0, condNonZero);
        addBranchTest(4'd5, 32'h100, condPlus);
        addBranchTest(4'd9, negWord, condPlus);
        addBranchTest(4'd9, negWord, condMinus);
        addBranchTest(4'd5, 32'h100, condMinus);
        putWord(encodeR(opHalt, 4'd0, 4'd0, 4'd0));
    endtask

    task automatic preloadProgram();
        for (int i = 0; i < prog.size(); i++) begin
            @(negedge clock);
            loadEn   = 1'b1;
            loadAddr = i[memAddrBits-1:0];
            loadData = prog[i];
        end
        @(negedge clock);
        loadEn    = 1'b0;
        holdReset = 1'b0;                       // lets reset go.
    endtask

    task automatic watchdog();
        repeat (limitCycles) @(posedge clock);
        $display("Timeout: program did not halt within %0d cycles", limitCycles);
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    // second in reads wordB.
    always @(negedge clock) begin
        if (rstN === 1'b1 && outStrobe === 1'b1) begin
            strobeCount++;
            if (strobeCount == 1)
                inPortData = wordB;
        end
    end

    // consume one expected word per strobe.
    always @(posedge clock) begin
        if (outStrobe === 1'b1 && expQ.size() > 0) begin
            void'(expQ.pop_front());
            expCount <= expQ.size();
            expHead  <= (expQ.size() > 0) ? expQ[0] : '0;
        end
    end

    resetQuiet: assert property (@(posedge clock) !rstN |=> !halted && !outStrobe)
        else begin
            $display("halted or outStrobe high during reset at %0t", $time);
            $display("CHECKS FAILED");
            $fatal(1);
        end

    noExtraOutput: assert property (@(posedge clock) disable iff (!rstN)
        outStrobe |-> expCount != 0)
        else begin
            $display("outStrobe pulsed with no output expected at %0t", $time);
            $display("CHECKS FAILED");
            $fatal(1);
        end

    outputValue: assert property (@(posedge clock) disable iff (!rstN)
        outStrobe && expCount != 0 |-> outPortData == expHead)
        else begin
            $display("Mismatch at %0t: outPortData expected %h, actual %h",
                     $time, $sampled(expHead), $sampled(outPortData));
            $display("CHECKS FAILED");
            $fatal(1);
        end

    haltAfterOutputs: assert property (@(posedge clock) disable iff (!rstN)
        $rose(halted) |-> expCount == 0)
        else begin
            $display("halted rose with %0d outputs still missing", $sampled(expCount));
            $display("CHECKS FAILED");
            $fatal(1);
        end

    haltFinal: assert property (@(posedge clock) disable iff (!rstN)
        halted |=> halted && !outStrobe)
        else begin
            $display("halted dropped or outStrobe pulsed after halt at %0t", $time);
            $display("CHECKS FAILED");
            $fatal(1);
        end

    initial begin
        holdReset   = 1'b1;
        loadEn      = 1'b0;
        loadAddr    = '0;
        loadData    = '0;
        inPortData  = '0;
        strobeCount = 0;
        void'($urandom(32'h8e6919da));
        buildProgram();
        inPortData  = wordA;                    // first in reads this.
        expCount    = expQ.size();
        expHead     = expQ[0];
        // preload and reset plus 40 per instruction.
        limitCycles = prog.size() + resetCycles + cyclesPerInstr * prog.size() + slackCycles;
        fork
            watchdog();
        join_none
        preloadProgram();
        while (halted !== 1'b1)
            @(posedge clock);
        repeat (haltQuietCycles) @(posedge clock);
        if (expCount == 0) begin
            $display("ALL CHECKS PASSED");
            $finish;
        end else begin
            $display("%0d expected outputs never appeared", expCount);
            $display("CHECKS FAILED");
            $fatal(1);
        end
    end

endmodule

// File: build.f
common/srcPkg.sv
common/ctrlIf.sv
hw/controlSequencer/controlSequencer.sv
hw/datapath/regBank.sv
hw/datapath/aluUnit.sv
hw/datapath/memInterface.sv
hw/miniSrc.sv
sim/clockGen.sv
sim/miniSrcTb.sv
